// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tbFetchUnit
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/adder16.sv ====
`default_nettype none

module adder16 import cpuPkg::*; (
  input  word_t a,
  input  word_t b,
  input  logic  cin,
  output word_t sum,
  output logic  cout
);

  wire [15:0] gen;                      // per-bit generate
  wire [15:0] prop;                     // per-bit propagate
  wire [16:0] carry;                    // carry into each bit, [16] is carry out
  wire [3:0]  grpGen;                   // group generate
  wire [3:0]  grpProp;                  // group propagate

  assign gen  = a & b;
  assign prop = a ^ b;

  assign carry[0] = cin;

  // four 4-bit lookahead groups
  genvar k;
  generate
    for (k = 0; k < 4; k++) begin : grp
      localparam int B = 4 * k;         // lowest bit of this group
      assign carry[B+1] = gen[B] | (prop[B] & carry[B]);
      assign carry[B+2] = gen[B+1] | (prop[B+1] & gen[B])
                        | (prop[B+1] & prop[B] & carry[B]);
      assign carry[B+3] = gen[B+2] | (prop[B+2] & gen[B+1])
                        | (prop[B+2] & prop[B+1] & gen[B])
                        | (prop[B+2] & prop[B+1] & prop[B] & carry[B]);
      assign grpGen[k]  = gen[B+3] | (prop[B+3] & gen[B+2])
                        | (prop[B+3] & prop[B+2] & gen[B+1])
                        | (prop[B+3] & prop[B+2] & prop[B+1] & gen[B]);
      assign grpProp[k] = &prop[B+3:B];
    end
  endgenerate

  // second level, carries into groups 1..3 and the carry out
  assign carry[4]  = grpGen[0] | (grpProp[0] & cin);
  assign carry[8]  = grpGen[1] | (grpProp[1] & grpGen[0])
                   | (grpProp[1] & grpProp[0] & cin);
  assign carry[12] = grpGen[2] | (grpProp[2] & grpGen[1])
                   | (grpProp[2] & grpProp[1] & grpGen[0])
                   | (grpProp[2] & grpProp[1] & grpProp[0] & cin);
  assign carry[16] = grpGen[3] | (grpProp[3] & grpGen[2])
                   | (grpProp[3] & grpProp[2] & grpGen[1])
                   | (grpProp[3] & grpProp[2] & grpProp[1] & grpGen[0])
                   | (&grpProp & cin);

  assign sum  = prop ^ carry[15:0];
  assign cout = carry[16];

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  typedef logic [15:0] word_t;          // data or byte address
  typedef logic [3:0] opcode_t;         // top nibble of the instruction
  typedef logic [2:0] cond_t;           // branch condition code
  typedef logic signed [8:0] offset_t;  // branch offset in instructions

  // control-flow opcodes, everything else just steps the pc
  localparam opcode_t OP_B   = 4'd12;   // immediate branch
  localparam opcode_t OP_BR  = 4'd13;   // branch to register
  localparam opcode_t OP_PCS = 4'd14;   // pc save
  localparam opcode_t OP_HLT = 4'd15;   // halt

  typedef struct packed {
    logic n;                            // negative
    logic v;                            // overflow
    logic z;                            // zero
  } flags_t;

  // one decoded control-flow request per cycle, 32 bits
  typedef struct packed {
    opcode_t op;
    cond_t   cond;
    offset_t offset;
    word_t   regTarget;                 // register value for BR
  } branchReq_t;

  // alu writeback toward the flag register, 20 bits
  typedef struct packed {
    word_t  result;
    logic   overflow;
    flags_t writeMask;                  // one enable per flag
  } aluWb_t;

  typedef enum logic {
    RUN,
    HALTED
  } seqState_t;

endpackage

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`default_nettype none

module fetchUnit import cpuPkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  branchReq_t req,               // decoded control-flow request
  input  aluWb_t     aluWb,             // alu flag writeback
  output word_t      pc,
  output flags_t     flags,
  output logic       halted
);

  word_t nextPc;                        // pcControl -> sequencer
  logic  haltReq;

  pcSequencer #(
    .RESET_PC (RESET_PC)
  ) seq0 (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .nextPc  (nextPc),
    .haltReq (haltReq),
    .pc      (pc),
    .halted  (halted)
  );

  pcControl ctl0 (
    .pc      (pc),
    .req     (req),
    .flags   (flags),                   // registered flags, pre-write
    .nextPc  (nextPc),
    .haltReq (haltReq)
  );

  flagRegister flg0 (
    .clk   (clk),
    .reset (reset),
    .aluWb (aluWb),
    .flags (flags)
  );

endmodule

`default_nettype wire

// ==== hdl/flagRegister.sv ====
`default_nettype none

module flagRegister import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  aluWb_t aluWb,
  output flags_t flags
);

  flags_t newFlags;                     // flags as derived from the result

  // derive candidate flags from the writeback
  always_comb begin
    newFlags.n = aluWb.result[15];      // sign bit
    newFlags.v = aluWb.overflow;
    newFlags.z = (aluWb.result == '0);
  end

  // each flag loads only where its mask bit is set
  // runs regardless of stall or halt
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (aluWb.writeMask.n) begin
        flags.n <= newFlags.n;
      end
      if (aluWb.writeMask.v) begin
        flags.v <= newFlags.v;
      end
      if (aluWb.writeMask.z) begin
        flags.z <= newFlags.z;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pcControl.sv ====
`default_nettype none

module pcControl import cpuPkg::*; (
  input  word_t      pc,
  input  branchReq_t req,
  input  flags_t     flags,             // flags before this cycle's write
  output word_t      nextPc,
  output logic       haltReq
);

  word_t pcPlus2;                       // sequential successor
  word_t offsetShift;                   // sign-extended offset in bytes
  word_t branchTarget;                  // pc+2 plus offset
  logic  takeBranch;                    // condition holds

  // offset counts instructions, instructions are 2 bytes
  assign offsetShift = {{6{req.offset[8]}}, req.offset, 1'b0};

  adder16 incAdder (
    .a    (pc),
    .b    (word_t'(2)),
    .cin  (1'b0),
    .sum  (pcPlus2),
    .cout ()                            // wraps mod 2^16
  );

  adder16 tgtAdder (
    .a    (pcPlus2),
    .b    (offsetShift),
    .cin  (1'b0),
    .sum  (branchTarget),
    .cout ()
  );

  // condition code against n/v/z
  always_comb begin
    case (req.cond)
      3'd0:    takeBranch = ~flags.z;                // not equal
      3'd1:    takeBranch = flags.z;                 // equal
      3'd2:    takeBranch = ~flags.z & ~flags.n;     // greater than
      3'd3:    takeBranch = flags.n;                 // less than
      3'd4:    takeBranch = flags.z | ~flags.n;      // greater or equal
      3'd5:    takeBranch = flags.n | flags.z;       // less or equal
      3'd6:    takeBranch = flags.v;                 // overflow
      default: takeBranch = 1'b1;                    // unconditional
    endcase
  end

  // next pc by opcode
  always_comb begin
    case (req.op)
      OP_B:    nextPc = takeBranch ? branchTarget : pcPlus2;
      OP_BR:   nextPc = takeBranch ? req.regTarget : pcPlus2;
      OP_PCS:  nextPc = pcPlus2;        // link write lives elsewhere
      OP_HLT:  nextPc = pc;             // hold on halt
      default: nextPc = pcPlus2;
    endcase
  end

  assign haltReq = (req.op == OP_HLT);

endmodule

`default_nettype wire

// ==== hdl/pcSequencer.sv ====
`default_nettype none

module pcSequencer import cpuPkg::*; #(
  parameter word_t RESET_PC = '0        // must be even
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,                  // hold pc and state
  input  word_t nextPc,
  input  logic  haltReq,
  output word_t pc,
  output logic  halted
);

  seqState_t state;
  seqState_t stateNext;
  logic      advance;                   // pc loads this edge

  assign advance = (state == RUN) && !stall;

  always_comb begin
    stateNext = state;
    case (state)
      RUN: begin
        if (!stall && haltReq) begin
          stateNext = HALTED;           // same edge that accepts HLT
        end
      end
      HALTED: begin
        stateNext = HALTED;             // only reset leaves
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RUN;
      pc    <= RESET_PC;
    end else begin
      state <= stateNext;
      if (advance) begin
        pc <= nextPc;
      end
    end
  end

  assign halted = (state == HALTED);

endmodule

`default_nettype wire

// ==== tests/tbFetchUnit.sv ====
`default_nettype none

module tbFetchUnit import cpuPkg::*; ();

  localparam word_t RESET_PC   = 16'hFFF0;  // near the top so pc wraps early
  localparam int    RAND_STEPS = 600;
  localparam int    HALT_WAIT  = 20;         // cycles allowed for halted to rise

  logic       clk = 1'b0;
  logic       reset;
  logic       stall;
  branchReq_t req;
  aluWb_t     aluWb;
  word_t      pc;
  flags_t     flags;
  logic       halted;

  integer seed = 49827;

  word_t  modelPc;                           // reference state
  flags_t modelFlags;
  logic   modelHalted;
  word_t  expPc;                             // predicted before the edge
  flags_t expFlags;
  logic   expHalted;

  fetchUnit #(
    .RESET_PC (RESET_PC)
  ) dut0 (
    .clk    (clk),
    .reset  (reset),
    .stall  (stall),
    .req    (req),
    .aluWb  (aluWb),
    .pc     (pc),
    .flags  (flags),
    .halted (halted)
  );

  always #2 clk = ~clk;                      // period 4

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic checkFlags(input flags_t got, input flags_t exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR %0t: flags nvz is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic int randBelow(input int n);
    return {$random(seed)} % n;              // unsigned view, never negative
  endfunction

  // condition table indexed by code
  function automatic logic condHolds(input cond_t c, input flags_t f);
    logic [7:0] tbl;
    tbl = {1'b1, f.v, f.n | f.z, f.z | !f.n, f.n, !f.z && !f.n, f.z, !f.z};
    return tbl[c];
  endfunction

  function automatic word_t modelNextPc(input branchReq_t r, input word_t p);
    int    off;
    word_t seqPc;
    off   = int'($signed(r.offset));         // instructions, sign kept
    seqPc = p + 16'd2;                        // wraps by width
    if (r.op == OP_HLT) return p;
    if (r.op == OP_B && condHolds(r.cond, modelFlags)) begin
      return word_t'(int'(seqPc) + 2 * off); // mod 2^16 by truncation
    end
    if (r.op == OP_BR && condHolds(r.cond, modelFlags)) return r.regTarget;
    return seqPc;                            // PCS and ordinary opcodes
  endfunction

  function automatic flags_t modelFlagsNext(input aluWb_t w, input flags_t f);
    flags_t nf;
    nf = f;
    if (w.writeMask.z) nf.z = (w.result == 16'd0);
    if (w.writeMask.n) nf.n = w.result[15];
    if (w.writeMask.v) nf.v = w.overflow;
    return nf;
  endfunction

  // weighted toward B, BR and ordinary opcodes, PCS rare, never HLT
  function automatic branchReq_t randReq();
    branchReq_t r;
    int         pick;
    pick = randBelow(16);
    if (pick < 5) r.op = OP_B;
    else if (pick < 9) r.op = OP_BR;
    else if (pick == 9) r.op = OP_PCS;
    else r.op = opcode_t'(randBelow(12));    // 0..11
    r.cond      = cond_t'(randBelow(8));
    r.offset    = offset_t'($random(seed));  // both signs
    r.regTarget = word_t'($random(seed));
    return r;
  endfunction

  function automatic aluWb_t randWb();
    aluWb_t w;
    if (randBelow(6) == 0) w.result = '0;    // force zero results now and then
    else w.result = word_t'($random(seed));  // about half negative
    w.overflow  = (randBelow(2) == 1);
    w.writeMask = flags_t'(randBelow(8));
    return w;
  endfunction

  function automatic branchReq_t nopReq();
    branchReq_t r;
    r    = '0;
    r.op = 4'd1;                             // ordinary opcode
    return r;
  endfunction

  // drive at +1 after the edge, predict at the falling edge, check after the next edge
  task automatic stepCycle(input branchReq_t r, input aluWb_t w, input logic s);
    req   = r;
    aluWb = w;
    stall = s;
    @(negedge clk);
    expPc     = modelPc;
    expHalted = modelHalted;
    if (!modelHalted && !s) begin
      expPc     = modelNextPc(r, modelPc);
      expHalted = (r.op == OP_HLT);
    end
    expFlags = modelFlagsNext(w, modelFlags); // flags ignore stall and halt
    @(posedge clk);
    #1;
    modelPc     = expPc;
    modelFlags  = expFlags;
    modelHalted = expHalted;
    checkWord("pc", pc, modelPc);
    checkFlags(flags, modelFlags);
    checkBit("halted", halted, modelHalted);
  endtask

  task automatic applyReset();
    reset = 1'b1;
    stall = 1'b0;
    req   = '0;
    aluWb = '0;
    repeat (2) @(posedge clk);
    #1;
    reset       = 1'b0;
    modelPc     = RESET_PC;
    modelFlags  = '0;
    modelHalted = 1'b0;
    checkWord("pc after reset", pc, RESET_PC);
    checkFlags(flags, '0);
    checkBit("halted after reset", halted, 1'b0);
  endtask

  initial begin
    branchReq_t r;
    aluWb_t     w;
    int         waited;
    word_t      holdPc;
    applyReset();
    // sequential stepping across the wrap at 2^16
    for (int i = 0; i < 12; i++) begin
      r    = randReq();
      r.op = (i % 3 == 0) ? OP_PCS : opcode_t'(randBelow(12));
      stepCycle(r, '0, 1'b0);
    end
    checkWord("pc after wrap", pc, RESET_PC + 16'd24);
    for (int i = 0; i < RAND_STEPS; i++) begin
      stepCycle(randReq(), randWb(), randBelow(8) == 0); // stall about 1 in 8
    end
    // every condition code on B, with a fresh flag write alongside
    for (int c = 0; c < 8; c++) begin
      w           = randWb();
      w.writeMask = 3'b111;
      stepCycle(nopReq(), w, 1'b0);          // load all flags
      r      = randReq();
      r.op   = OP_B;
      r.cond = cond_t'(c);
      stepCycle(r, randWb(), 1'b0);          // branch sees the old flags
    end
    r      = randReq();
    r.op   = OP_HLT;
    waited = 0;
    while (halted !== 1'b1 && waited < HALT_WAIT) begin
      stepCycle(r, randWb(), waited < 2);    // stalled HLT must not halt
      waited++;
    end
    if (halted !== 1'b1) begin
      failRun("the unit never reached the halted state after HLT was presented");
    end
    holdPc = pc;
    for (int i = 0; i < 30; i++) begin
      r = randReq();
      if (randBelow(4) == 0) r.op = OP_HLT;
      stepCycle(r, randWb(), randBelow(4) == 0);
      checkWord("held pc", pc, holdPc);      // frozen while halted
    end
    applyReset();                            // only reset leaves HALTED
    for (int i = 0; i < 20; i++) begin
      stepCycle(randReq(), randWb(), 1'b0);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/cpuPkg.sv
hdl/adder16.sv
hdl/pcControl.sv
hdl/flagRegister.sv
hdl/pcSequencer.sv
hdl/fetchUnit.sv
tests/tbFetchUnit.sv
